//--- source/tage_pkg.sv
package tage_pkg;

	localparam int PC_WIDTH = 32;

	// bit 0 is the newest outcome
	localparam int HIST_WIDTH = 32;

	localparam int TAGE_BANKS = 4;
	localparam int BANK_IDX_WIDTH = $clog2(TAGE_BANKS);

	// 64 entries per tagged table
	localparam int SET_WIDTH = 6;
	localparam int TAG_WIDTH = 8;

	// one history length per bank, shortest first
	localparam int HIST_LEN [TAGE_BANKS] = '{4, 8, 16, 32};

	// tagged counter, msb is the direction
	localparam int CTR_WIDTH = 3;
	localparam logic [CTR_WIDTH-1:0] CTR_WEAK_TAKEN = CTR_WIDTH'(1 << (CTR_WIDTH - 1));
	localparam logic [CTR_WIDTH-1:0] CTR_WEAK_NOT_TAKEN = CTR_WIDTH'((1 << (CTR_WIDTH - 1)) - 1);

	localparam int U_WIDTH = 2;

	// bimodal base table
	localparam int BASE_WIDTH = 8;
	localparam int BASE_CTR_WIDTH = 2;
	// weakly not taken
	localparam logic [BASE_CTR_WIDTH-1:0] BASE_CTR_RESET = BASE_CTR_WIDTH'(1);

	// failed allocations before the useful bits get cleared
	localparam int UFAIL_WIDTH = 4;

endpackage

//--- source/tage_table_if.sv
`timescale 1ns/10ps

interface tage_table_if #(
	parameter int SET_WIDTH = tage_pkg::SET_WIDTH,
	parameter int TAG_WIDTH = tage_pkg::TAG_WIDTH
);
	// lookup and update addressing
	logic lookup_en;
	logic [SET_WIDTH-1:0] lookup_idx;
	logic [TAG_WIDTH-1:0] lookup_tag;
	logic [SET_WIDTH-1:0] update_idx;
	logic [TAG_WIDTH-1:0] update_tag;

	// registered lookup result
	logic hit;
	logic [tage_pkg::CTR_WIDTH-1:0] ctr;
	logic [tage_pkg::U_WIDTH-1:0] u;

	// combinational read at the update index
	logic update_hit;
	logic [tage_pkg::CTR_WIDTH-1:0] update_ctr;
	logic [tage_pkg::U_WIDTH-1:0] update_u;

	// update writes
	logic ctr_we;
	logic [tage_pkg::CTR_WIDTH-1:0] ctr_wdata;
	logic alloc;
	logic u_we;
	logic [tage_pkg::U_WIDTH-1:0] u_wdata;
	logic u_reset;

	modport tbl (
		input lookup_en, lookup_idx, lookup_tag, update_idx, update_tag,
		input ctr_we, ctr_wdata, alloc, u_we, u_wdata, u_reset,
		output hit, ctr, u, update_hit, update_ctr, update_u
	);

	modport ctrl (
		input update_hit, update_ctr, update_u,
		output ctr_we, ctr_wdata, alloc, u_we, u_wdata, u_reset
	);

endinterface

//--- source/tage_hash.sv
`timescale 1ns/10ps

module tage_hash #(
	parameter int HIST_LEN = 4,
	parameter int SET_WIDTH = tage_pkg::SET_WIDTH,
	parameter int TAG_WIDTH = tage_pkg::TAG_WIDTH
) (
	input logic [tage_pkg::PC_WIDTH-1:0] pc,
	input logic [tage_pkg::HIST_WIDTH-1:0] hist,
	output logic [SET_WIDTH-1:0] index,
	output logic [TAG_WIDTH-1:0] tag
);
	logic [SET_WIDTH-1:0] fold_idx;
	logic [TAG_WIDTH-1:0] fold_tag;
	logic [TAG_WIDTH-2:0] fold_tag_short;
	logic [SET_WIDTH-1:0] pc_high;

	// xor of width-sized chunks, so history bit i lands on bit i mod width
	always_comb begin
		fold_idx = '0;
		fold_tag = '0;
		fold_tag_short = '0;
		for (int i = 0; i < HIST_LEN; i++) begin
			fold_idx[i % SET_WIDTH] = fold_idx[i % SET_WIDTH] ^ hist[i];
			fold_tag[i % TAG_WIDTH] = fold_tag[i % TAG_WIDTH] ^ hist[i];
			fold_tag_short[i % (TAG_WIDTH - 1)] = fold_tag_short[i % (TAG_WIDTH - 1)] ^ hist[i];
		end
	end

	assign pc_high = SET_WIDTH'(pc >> (SET_WIDTH + 2));

	// instruction offset bits dropped
	assign index = pc[SET_WIDTH+1:2] ^ pc_high ^ fold_idx;

	// second fold shifted so the two folds do not cancel
	assign tag = pc[TAG_WIDTH+1:2] ^ fold_tag ^ {fold_tag_short, 1'b0};

endmodule

//--- source/tage_table.sv
`timescale 1ns/10ps

module tage_table #(
	parameter int SET_WIDTH = tage_pkg::SET_WIDTH,
	parameter int TAG_WIDTH = tage_pkg::TAG_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic stall,
	tage_table_if.tbl tif
);
	localparam int DEPTH = 2 ** SET_WIDTH;
	localparam int CW = tage_pkg::CTR_WIDTH;
	localparam int UW = tage_pkg::U_WIDTH;

	logic [DEPTH-1:0] valid;
	logic [TAG_WIDTH-1:0] tags [DEPTH];
	logic [CW-1:0] ctrs [DEPTH];
	logic [UW-1:0] useful [DEPTH];

	logic lookup_fire;
	logic valid_q;
	logic [CW-1:0] ctr_q;
	logic [UW-1:0] u_q;
	logic [TAG_WIDTH-1:0] entry_tag_q;
	logic [TAG_WIDTH-1:0] lookup_tag_q;

	assign lookup_fire = tif.lookup_en && !stall;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
			ctr_q <= '0;
			u_q <= '0;
		end else if (lookup_fire) begin
			valid_q <= valid[tif.lookup_idx];
			ctr_q <= ctrs[tif.lookup_idx];
			u_q <= useful[tif.lookup_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_fire) begin
			entry_tag_q <= tags[tif.lookup_idx];
			lookup_tag_q <= tif.lookup_tag;
		end
	end

	assign tif.hit = valid_q && entry_tag_q == lookup_tag_q;
	assign tif.ctr = ctr_q;
	assign tif.u = u_q;

	assign tif.update_hit = valid[tif.update_idx] && tags[tif.update_idx] == tif.update_tag;
	assign tif.update_ctr = ctrs[tif.update_idx];
	assign tif.update_u = useful[tif.update_idx];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				tags[i] <= '0;
				ctrs[i] <= '0;
				useful[i] <= '0;
			end
		end else begin
			if (tif.alloc) begin
				valid[tif.update_idx] <= 1'b1;
				tags[tif.update_idx] <= tif.update_tag;
			end
			if (tif.alloc || tif.ctr_we)
				ctrs[tif.update_idx] <= tif.ctr_wdata;
			// global clear wins over a single write
			if (tif.u_reset) begin
				for (int i = 0; i < DEPTH; i++)
					useful[i] <= '0;
			end else if (tif.u_we) begin
				useful[tif.update_idx] <= tif.u_wdata;
			end
		end
	end

	// only entries that are not useful may be replaced
	assert property (@(posedge clk) disable iff (rst)
		tif.alloc |-> !valid[tif.update_idx] || useful[tif.update_idx] == '0);

	// useful bits are only ever earned by valid entries
	assert property (@(posedge clk) disable iff (rst)
		tif.u != '0 |-> valid_q);

endmodule

//--- source/tage_base.sv
`timescale 1ns/10ps

module tage_base (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic [tage_pkg::BASE_WIDTH-1:0] lookup_idx,
	output logic [tage_pkg::BASE_CTR_WIDTH-1:0] lookup_ctr,
	input logic [tage_pkg::BASE_WIDTH-1:0] update_idx,
	output logic [tage_pkg::BASE_CTR_WIDTH-1:0] update_ctr,
	input logic write_en,
	input logic [tage_pkg::BASE_CTR_WIDTH-1:0] write_ctr
);
	localparam int DEPTH = 2 ** tage_pkg::BASE_WIDTH;

	logic [tage_pkg::BASE_CTR_WIDTH-1:0] ctrs [DEPTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				ctrs[i] <= tage_pkg::BASE_CTR_RESET;
		end else if (write_en) begin
			ctrs[update_idx] <= write_ctr;
		end
	end

	// lookup stage freezes while stalled
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lookup_ctr <= tage_pkg::BASE_CTR_RESET;
		else if (!stall)
			lookup_ctr <= ctrs[lookup_idx];
	end

	// sees all earlier training writes
	assign update_ctr = ctrs[update_idx];

endmodule

//--- source/tage_update.sv
`timescale 1ns/10ps

module tage_update (
	input logic clk,
	input logic rst,
	input logic update,
	input logic taken,
	input logic [tage_pkg::BASE_CTR_WIDTH-1:0] base_ctr,
	output logic base_we,
	output logic [tage_pkg::BASE_CTR_WIDTH-1:0] base_wctr,
	tage_table_if.ctrl tif [tage_pkg::TAGE_BANKS]
);
	localparam int BANKS = tage_pkg::TAGE_BANKS;
	localparam int IW = tage_pkg::BANK_IDX_WIDTH;
	localparam int CW = tage_pkg::CTR_WIDTH;
	localparam int UW = tage_pkg::U_WIDTH;
	localparam int BCW = tage_pkg::BASE_CTR_WIDTH;

	logic [BANKS-1:0] hit;
	logic [CW-1:0] ctr [BANKS];
	logic [UW-1:0] u [BANKS];
	logic [BANKS-1:0] above;
	logic [BANKS-1:0] free;
	logic [BANKS-1:0] alloc_sel;
	logic prov_found;
	logic alt_found;
	logic [IW-1:0] prov_idx;
	logic [IW-1:0] alt_idx;
	logic pred;
	logic alt_pred;
	logic mispred;
	logic alloc_found;
	logic alloc_fail;
	logic [tage_pkg::UFAIL_WIDTH-1:0] ufail;
	logic u_reset;

	// highest hit provides, the one before it is the alternate
	always_comb begin
		prov_found = 1'b0;
		alt_found = 1'b0;
		prov_idx = '0;
		alt_idx = '0;
		for (int i = 0; i < BANKS; i++) begin
			if (hit[i]) begin
				alt_found = prov_found;
				alt_idx = prov_idx;
				prov_found = 1'b1;
				prov_idx = IW'(i);
			end
		end
	end

	assign pred = prov_found ? ctr[prov_idx][CW-1] : base_ctr[BCW-1];
	assign alt_pred = alt_found ? ctr[alt_idx][CW-1] : base_ctr[BCW-1];
	assign mispred = pred != taken;

	// non-useful banks above the provider
	always_comb begin
		for (int i = 0; i < BANKS; i++) begin
			above[i] = !prov_found || IW'(i) > prov_idx;
			free[i] = above[i] && u[i] == '0;
		end
	end

	assign alloc_found = |free;
	assign alloc_fail = update && mispred && |above && !alloc_found;

	for (genvar i = 0; i < BANKS; i++) begin : g_bank
		logic is_prov;
		logic u_train;
		logic [CW-1:0] ctr_next;
		logic [UW-1:0] u_inc;
		logic [UW-1:0] u_dec;

		assign hit[i] = tif[i].update_hit;
		assign ctr[i] = tif[i].update_ctr;
		assign u[i] = tif[i].update_u;

		assign is_prov = prov_found && prov_idx == IW'(i);
		// lowest free bank wins
		assign alloc_sel[i] = update && mispred && free[i]
			&& (free & BANKS'((1 << i) - 1)) == '0;
		assign u_train = update && is_prov && pred != alt_pred;

		assign ctr_next = taken ? (&ctr[i] ? ctr[i] : ctr[i] + 1'b1)
			: (|ctr[i] ? ctr[i] - 1'b1 : ctr[i]);
		assign u_inc = &u[i] ? u[i] : u[i] + 1'b1;
		assign u_dec = |u[i] ? u[i] - 1'b1 : u[i];

		assign tif[i].ctr_we = update && is_prov;
		assign tif[i].ctr_wdata = !alloc_sel[i] ? ctr_next
			: (taken ? tage_pkg::CTR_WEAK_TAKEN : tage_pkg::CTR_WEAK_NOT_TAKEN);
		assign tif[i].alloc = alloc_sel[i];
		assign tif[i].u_we = alloc_sel[i] || u_train || (alloc_fail && above[i]);
		assign tif[i].u_wdata = alloc_sel[i] ? '0 : (u_train && !mispred ? u_inc : u_dec);
		assign tif[i].u_reset = u_reset;
	end

	// base trains only when no tagged table provided
	assign base_we = update && !prov_found;
	assign base_wctr = taken ? (&base_ctr ? base_ctr : base_ctr + 1'b1)
		: (|base_ctr ? base_ctr - 1'b1 : base_ctr);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ufail <= '0;
			u_reset <= 1'b0;
		end else begin
			u_reset <= 1'b0;
			if (alloc_fail) begin
				ufail <= ufail + 1'b1;
				// counter wraps, clear every useful bit next edge
				if (&ufail)
					u_reset <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		update |-> $onehot0(alloc_sel));

endmodule

//--- source/tage_predictor.sv
`timescale 1ns/10ps

module tage_predictor #(
	parameter int SET_WIDTH = tage_pkg::SET_WIDTH,
	parameter int TAG_WIDTH = tage_pkg::TAG_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic lookup,
	input logic [tage_pkg::PC_WIDTH-1:0] pc,
	input logic [tage_pkg::HIST_WIDTH-1:0] hist,
	input logic update,
	input logic [tage_pkg::PC_WIDTH-1:0] update_pc,
	input logic [tage_pkg::HIST_WIDTH-1:0] update_hist,
	input logic update_taken,
	output logic pred_valid,
	output logic pred_taken,
	output logic pred_hit,
	output logic [tage_pkg::BANK_IDX_WIDTH-1:0] pred_provider,
	output logic pred_alt
);
	localparam int BANKS = tage_pkg::TAGE_BANKS;
	localparam int IW = tage_pkg::BANK_IDX_WIDTH;
	localparam int PCW = tage_pkg::PC_WIDTH;
	localparam int BW = tage_pkg::BASE_WIDTH;
	localparam int BCW = tage_pkg::BASE_CTR_WIDTH;

	logic [BANKS-1:0] hit;
	logic [BANKS-1:0] bank_taken;
	logic prov_found;
	logic alt_found;
	logic [IW-1:0] prov_idx;
	logic [IW-1:0] alt_idx;
	logic [BW-1:0] base_lookup_idx;
	logic [BW-1:0] base_update_idx;
	logic [BCW-1:0] base_lookup_ctr;
	logic [BCW-1:0] base_update_ctr;
	logic [BCW-1:0] base_wctr;
	logic base_we;

	tage_table_if #(.SET_WIDTH(SET_WIDTH), .TAG_WIDTH(TAG_WIDTH)) tif [BANKS] ();

	for (genvar i = 0; i < BANKS; i++) begin : g_bank
		tage_hash #(
			.HIST_LEN(tage_pkg::HIST_LEN[i]),
			.SET_WIDTH(SET_WIDTH),
			.TAG_WIDTH(TAG_WIDTH)
		) lookup_hash (
			.pc(pc),
			.hist(hist),
			.index(tif[i].lookup_idx),
			.tag(tif[i].lookup_tag)
		);

		tage_hash #(
			.HIST_LEN(tage_pkg::HIST_LEN[i]),
			.SET_WIDTH(SET_WIDTH),
			.TAG_WIDTH(TAG_WIDTH)
		) update_hash (
			.pc(update_pc),
			.hist(update_hist),
			.index(tif[i].update_idx),
			.tag(tif[i].update_tag)
		);

		tage_table #(.SET_WIDTH(SET_WIDTH), .TAG_WIDTH(TAG_WIDTH)) bank_table (
			.clk(clk),
			.rst(rst),
			.stall(stall),
			.tif(tif[i])
		);

		assign tif[i].lookup_en = lookup;
		assign hit[i] = tif[i].hit;
		assign bank_taken[i] = tif[i].ctr[tage_pkg::CTR_WIDTH-1];
	end

	assign base_lookup_idx = pc[BW+1:2] ^ pc[PCW-1 -: BW];
	assign base_update_idx = update_pc[BW+1:2] ^ update_pc[PCW-1 -: BW];

	tage_base base_table (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.lookup_idx(base_lookup_idx),
		.lookup_ctr(base_lookup_ctr),
		.update_idx(base_update_idx),
		.update_ctr(base_update_ctr),
		.write_en(base_we),
		.write_ctr(base_wctr)
	);

	tage_update update_ctrl (
		.clk(clk),
		.rst(rst),
		.update(update),
		.taken(update_taken),
		.base_ctr(base_update_ctr),
		.base_we(base_we),
		.base_wctr(base_wctr),
		.tif(tif)
	);

	// provider is the longest history that hit
	always_comb begin
		prov_found = 1'b0;
		alt_found = 1'b0;
		prov_idx = '0;
		alt_idx = '0;
		for (int i = 0; i < BANKS; i++) begin
			if (hit[i]) begin
				alt_found = prov_found;
				alt_idx = prov_idx;
				prov_found = 1'b1;
				prov_idx = IW'(i);
			end
		end
	end

	assign pred_hit = prov_found;
	assign pred_provider = prov_idx;
	assign pred_taken = prov_found ? bank_taken[prov_idx] : base_lookup_ctr[BCW-1];
	assign pred_alt = alt_found ? bank_taken[alt_idx] : base_lookup_ctr[BCW-1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pred_valid <= 1'b0;
		else
			pred_valid <= lookup && !stall;
	end

endmodule

//--- dv/tage_model.svh
`ifndef TAGE_MODEL_SVH
`define TAGE_MODEL_SVH

localparam int M_BANKS = tage_pkg::TAGE_BANKS;
localparam int M_SW = tage_pkg::SET_WIDTH;
localparam int M_TW = tage_pkg::TAG_WIDTH;
localparam int M_BW = tage_pkg::BASE_WIDTH;

logic m_valid [M_BANKS][2**M_SW];
logic [M_TW-1:0] m_tag [M_BANKS][2**M_SW];
logic [2:0] m_ctr [M_BANKS][2**M_SW];
logic [1:0] m_u [M_BANKS][2**M_SW];
logic [1:0] m_base [2**M_BW];
logic [3:0] m_ufail;
logic m_ureset_pend;
int m_resets;

task automatic model_reset();
	for (int b = 0; b < M_BANKS; b++) begin
		for (int i = 0; i < 2**M_SW; i++) begin
			m_valid[b][i] = 1'b0;
			m_tag[b][i] = '0;
			m_ctr[b][i] = '0;
			m_u[b][i] = '0;
		end
	end
	for (int i = 0; i < 2**M_BW; i++)
		m_base[i] = 2'd1;
	m_ufail = '0;
	m_ureset_pend = 1'b0;
	m_resets = 0;
endtask

// xor of w-bit chunks of the low len bits
function automatic logic [31:0] fold(input logic [31:0] h, input int len, input int w);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < len; i++)
		r[i % w] = r[i % w] ^ h[i];
	return r;
endfunction

function automatic int set_index(input int b, input logic [31:0] pc, input logic [31:0] h);
	logic [31:0] x;
	x = (pc >> 2) ^ (pc >> (M_SW + 2)) ^ fold(h, tage_pkg::HIST_LEN[b], M_SW);
	return int'(x[M_SW-1:0]);
endfunction

function automatic logic [M_TW-1:0] tag_of(input int b, input logic [31:0] pc,
		input logic [31:0] h);
	logic [31:0] x;
	x = (pc >> 2) ^ fold(h, tage_pkg::HIST_LEN[b], M_TW)
		^ (fold(h, tage_pkg::HIST_LEN[b], M_TW - 1) << 1);
	return x[M_TW-1:0];
endfunction

function automatic int base_index(input logic [31:0] pc);
	logic [31:0] x;
	x = (pc >> 2) ^ (pc >> (32 - M_BW));
	return int'(x[M_BW-1:0]);
endfunction

// {taken, hit, provider, alt}
function automatic logic [4:0] predict_ref(input logic [31:0] pc, input logic [31:0] h);
	int prov;
	int alt;
	int idx;
	logic base_dir;
	logic p;
	logic a;
	prov = -1;
	alt = -1;
	for (int b = 0; b < M_BANKS; b++) begin
		idx = set_index(b, pc, h);
		if (m_valid[b][idx] && m_tag[b][idx] == tag_of(b, pc, h)) begin
			alt = prov;
			prov = b;
		end
	end
	base_dir = m_base[base_index(pc)][1];
	p = prov >= 0 ? m_ctr[prov][set_index(prov, pc, h)][2] : base_dir;
	a = alt >= 0 ? m_ctr[alt][set_index(alt, pc, h)][2] : base_dir;
	return {p, prov >= 0, prov >= 0 ? 2'(prov) : 2'd0, a};
endfunction

// one clock edge of the update side, called on every edge out of reset
task automatic update_ref(input logic upd, input logic [31:0] pc, input logic [31:0] h,
		input logic taken);
	logic [4:0] r;
	int prov;
	int alt;
	int alloc;
	int bi;
	int pi;
	logic mis;
	logic fail;
	logic alt_dir;
	r = predict_ref(pc, h);
	prov = r[3] ? int'(r[2:1]) : -1;
	alt_dir = r[0];
	mis = r[4] != taken;
	alloc = -1;
	for (int b = M_BANKS - 1; b > prov; b--) begin
		if (m_u[b][set_index(b, pc, h)] == 0)
			alloc = b;
	end
	fail = upd && mis && prov < M_BANKS - 1 && alloc < 0;
	if (upd) begin
		bi = base_index(pc);
		if (prov >= 0) begin
			pi = set_index(prov, pc, h);
			if (taken && m_ctr[prov][pi] != 3'd7)
				m_ctr[prov][pi]++;
			else if (!taken && m_ctr[prov][pi] != 3'd0)
				m_ctr[prov][pi]--;
			if (r[4] != alt_dir) begin
				if (!mis && m_u[prov][pi] != 2'd3)
					m_u[prov][pi]++;
				else if (mis && m_u[prov][pi] != 2'd0)
					m_u[prov][pi]--;
			end
		end else begin
			if (taken && m_base[bi] != 2'd3)
				m_base[bi]++;
			else if (!taken && m_base[bi] != 2'd0)
				m_base[bi]--;
		end
		if (mis && alloc >= 0) begin
			pi = set_index(alloc, pc, h);
			m_valid[alloc][pi] = 1'b1;
			m_tag[alloc][pi] = tag_of(alloc, pc, h);
			m_ctr[alloc][pi] = taken ? 3'd4 : 3'd3;
			m_u[alloc][pi] = 2'd0;
		end
		if (fail) begin
			for (int b = prov + 1; b < M_BANKS; b++) begin
				pi = set_index(b, pc, h);
				if (m_u[b][pi] != 2'd0)
					m_u[b][pi]--;
			end
		end
	end
	// pending clear overrides this edge's useful writes
	if (m_ureset_pend) begin
		for (int b = 0; b < M_BANKS; b++)
			for (int i = 0; i < 2**M_SW; i++)
				m_u[b][i] = '0;
		m_resets++;
	end
	m_ureset_pend = fail && m_ufail == 4'hf;
	if (fail)
		m_ufail++;
endtask

`endif

//--- dv/tage_tb.sv
`timescale 1ns/10ps

module tage_tb;
	localparam int CYCLE_LIMIT = 6000;

	logic clk = 1'b0;
	logic rst;
	logic stall;
	logic lookup;
	logic [31:0] pc;
	logic [31:0] hist;
	logic update;
	logic [31:0] update_pc;
	logic [31:0] update_hist;
	logic update_taken;
	logic pred_valid;
	logic pred_taken;
	logic pred_hit;
	logic [tage_pkg::BANK_IDX_WIDTH-1:0] pred_provider;
	logic pred_alt;

	int errors = 0;
	int cycles = 0;
	int seed = 32'hbfc5_5f4f;
	logic [4:0] exp_pred;
	logic exp_valid = 1'b0;
	logic have_exp = 1'b0;
	logic [31:0] pool [4] = '{32'h0000_1a40, 32'h0040_2c18, 32'h8001_03f4, 32'h1234_5678};

	`include "tage_model.svh"

	tage_predictor #(
		.SET_WIDTH(tage_pkg::SET_WIDTH),
		.TAG_WIDTH(tage_pkg::TAG_WIDTH)
	) i_dut (.*);

	always #10 clk = ~clk;

	task automatic check_val(input string name, input logic [3:0] got, input logic [3:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	// drive one cycle, inputs change 2 ns after the edge
	task automatic cycle(input logic lk, input logic [31:0] lpc, input logic [31:0] lh,
			input logic up, input logic [31:0] upc, input logic [31:0] uh,
			input logic ut, input logic st);
		lookup = lk;
		pc = lpc;
		hist = lh;
		update = up;
		update_pc = upc;
		update_hist = uh;
		update_taken = ut;
		stall = st;
		@(posedge clk);
		#2;
	endtask

	// model sees the lookup before the update on the same edge
	always @(posedge clk) begin
		if (rst) begin
			model_reset();
		end else begin
			exp_valid = lookup && !stall;
			// a stalled edge keeps the last prediction on the outputs
			if (!stall)
				have_exp = lookup;
			if (lookup && !stall)
				exp_pred = predict_ref(pc, hist);
			update_ref(update, update_pc, update_hist, update_taken);
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			check_val("pred_valid", pred_valid, exp_valid);
			if (have_exp) begin
				check_val("pred_taken", pred_taken, exp_pred[4]);
				check_val("pred_hit", pred_hit, exp_pred[3]);
				check_val("pred_provider", pred_provider, exp_pred[2:1]);
				check_val("pred_alt", pred_alt, exp_pred[0]);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] h;
		logic t;
		rst = 1'b1;
		cycle(0, 0, 0, 0, 0, 0, 0, 0);
		repeat (9) @(posedge clk);
		#2;
		rst = 1'b0;

		// empty tables miss everywhere
		for (int i = 0; i < 16; i++) begin
			cycle(1, $random(seed), $random(seed), 0, 0, 0, 0, 0);
			check_val("pred_hit", pred_hit, 0);
			check_val("pred_taken", pred_taken, 0);
		end

		// base learns taken
		cycle(0, 0, 0, 1, 32'h0000_0400, 0, 1, 0);
		cycle(0, 0, 0, 1, 32'h0000_0400, 0, 1, 0);
		cycle(1, 32'h0000_0400, 0, 0, 0, 0, 0, 0);
		check_val("pred_alt", pred_alt, 1);

		// allocation walks up one bank per misprediction
		cycle(0, 0, 0, 1, 32'h0003_0080, 32'h55, 1, 0);
		cycle(1, 32'h0003_0080, 32'h55, 0, 0, 0, 0, 0);
		check_val("pred_hit", pred_hit, 1);
		check_val("pred_provider", pred_provider, 0);
		check_val("pred_taken", pred_taken, 1);
		cycle(0, 0, 0, 1, 32'h0003_0080, 32'h55, 0, 0);
		cycle(1, 32'h0003_0080, 32'h55, 0, 0, 0, 0, 0);
		check_val("pred_provider", pred_provider, 1);
		check_val("pred_taken", pred_taken, 0);

		// alternating branch
		h = '0;
		for (int i = 0; i < 200; i++) begin
			t = ~h[0];
			cycle(1, 32'h0000_2200, h, 1, 32'h0000_2200, h, t, 0);
			// learned by the end of the run
			if (i >= 180)
				check_val("pred_taken", pred_taken, t);
			h = {h[30:0], t};
		end

		// heavy random outcomes on few branches fill the useful bits
		for (int i = 0; i < 2000; i++) begin
			h = $random(seed) & 32'h7;
			cycle(1, pool[i % 4], h, 1, pool[$random(seed) & 3], h, $random(seed), 0);
		end

		// mixed traffic with stalls
		for (int i = 0; i < 1500; i++) begin
			cycle(1, pool[$random(seed) & 3], $random(seed) & 32'hff,
				$random(seed), pool[$random(seed) & 3], $random(seed) & 32'hff,
				$random(seed), ($random(seed) & 3) == 0);
		end
		cycle(0, 0, 0, 0, 0, 0, 0, 0);

		$display("errors: %0d, useful resets seen: %0d", errors, m_resets);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+dv
source/tage_pkg.sv
source/tage_table_if.sv
source/tage_hash.sv
source/tage_table.sv
source/tage_base.sv
source/tage_update.sv
source/tage_predictor.sv
dv/tage_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = tage_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
